/* project.f */
rtl/mipsPkg.sv
rtl/aluUnit.sv
rtl/regFile.sv
rtl/instrDecoder.sv
rtl/busSequencer.sv
rtl/mipsCpuBus.sv
dv/avalonMemModel.sv
dv/mipsCpuBusAsserts.sv
dv/mipsCpuBusTb.sv

/* Bender.yml */
package:
  name: mips_cpu_bus

sources:
  - files:
      - rtl/mipsPkg.sv
      - rtl/aluUnit.sv
      - rtl/regFile.sv
      - rtl/instrDecoder.sv
      - rtl/busSequencer.sv
      - rtl/mipsCpuBus.sv
  - target: simulation
    files:
      - dv/avalonMemModel.sv
      - dv/mipsCpuBusAsserts.sv
      - dv/mipsCpuBusTb.sv

/* dv/mipsCpuBusTb.sv */
// Testbench top for the CPU; loads a program into the memory model and checks v0 and the bus
`timescale 1ns/100ps

module mipsCpuBusTb;
    import mipsPkg::*;

    logic clk;
    logic reset;
    logic active;
    logic read;
    logic write;
    logic waitrequest;
    logic [3:0] byteenable;
    wordT register_v0;
    wordT address;
    wordT writedata;
    wordT readdata;

    // Reference register values and next program slot
    wordT x [32];
    wordT expA;
    int progIdx = 0;

    mipsCpuBus mipsCpuBus_inst (.*);

    avalonMemModel memModel_inst (
        .clk        (clk),
        .address    (address),
        .read       (read),
        .write      (write),
        .writedata  (writedata),
        .waitrequest(waitrequest),
        .readdata   (readdata)
    );

    bind mipsCpuBus mipsCpuBusAsserts busAsserts_inst (.*);

    always #20 clk = ~clk;

    task automatic failRun(input string why);
        $display("%s", why);
        $display("=== FAIL ===");
        $fatal(1, "Simulation stopped on error");
    endtask

    task automatic checkValue(input string name, input wordT got, input wordT want);
        assert (got === want) else
            failRun($sformatf("FAILED at %0t: %s = %h, expected %h", $time, name, got, want));
    endtask

    // Instruction encoders
    function automatic wordT rInstr(regIdxT rs, regIdxT rt, regIdxT rd, logic [4:0] sh,
                                    functT fn);
        return {opSpecial, rs, rt, rd, sh, fn};
    endfunction

    function automatic wordT iInstr(opcodeT op, regIdxT rs, regIdxT rt, logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic wordT jInstr(opcodeT op, wordT dest);
        return {op, dest[27:2]};
    endfunction

    function automatic wordT addrOf(int idx);
        return resetVector + 32'(4 * idx);
    endfunction

    task automatic loadNext(input wordT w);
        memModel_inst.mem[progIdx] = w;
        progIdx++;
    endtask

    // Completion of the fetch of a given program slot
    task automatic waitFetch(input int idx);
        for (int n = 0; n < 400; n++) begin
            @(posedge clk);
            if (read && !waitrequest && (address == addrOf(idx))) begin
                return;
            end
        end
        failRun($sformatf("Timed out waiting for the fetch of instruction %0d", idx));
    endtask

    task automatic waitWrite(input wordT wantAddr, input wordT wantData);
        for (int n = 0; n < 400; n++) begin
            @(posedge clk);
            if (write && !waitrequest) begin
                checkValue("address", address, wantAddr);
                checkValue("writedata", writedata, wantData);
                checkValue("byteenable", {28'd0, byteenable}, 32'hF);
                return;
            end
        end
        failRun("Timed out waiting for the store on the bus");
    endtask

    task automatic waitHalt();
        for (int n = 0; n < 40; n++) begin
            @(posedge clk);
            if (!active) begin
                return;
            end
        end
        failRun("CPU did not drop active after the jump to zero");
    endtask

    // Bound protocol checks count their failures
    always @(negedge clk) begin
        if (mipsCpuBus_inst.busAsserts_inst.failCount != 0) begin
            failRun("A bus protocol assertion failed");
        end
    end

    initial begin
        clk   = 1'b0;
        reset = 1'b1;
        // Unsupported opcode in the top bits, word index in the low bits
        for (int i = 0; i < 1024; i++) begin
            memModel_inst.mem[i] = 32'hFFFF_0000 | 32'(i);
        end
        // ALU chain
        loadNext(iInstr(opLui, 0, 8, 16'h8000));
        loadNext(iInstr(opOri, 8, 8, 16'h00F0));
        loadNext(iInstr(opAddiu, 0, 9, 16'hFFFD));
        loadNext(rInstr(8, 9, 10, 0, fnAddu));
        loadNext(rInstr(10, 9, 11, 0, fnSubu));
        loadNext(rInstr(10, 9, 12, 0, fnAnd));
        loadNext(rInstr(12, 9, 13, 0, fnXor));
        loadNext(rInstr(8, 13, 14, 0, fnSlt));
        loadNext(rInstr(13, 8, 15, 0, fnSltu));
        loadNext(rInstr(0, 13, 16, 4, fnSll));
        loadNext(rInstr(0, 8, 17, 8, fnSra));
        loadNext(rInstr(14, 17, 18, 0, fnSrlv));
        loadNext(iInstr(opSlti, 9, 19, 16'hFFFE));
        loadNext(rInstr(16, 18, 2, 0, fnAddu));
        loadNext(rInstr(2, 11, 2, 0, fnXor));
        loadNext(rInstr(2, 19, 2, 0, fnAddu));
        loadNext(rInstr(2, 15, 2, 0, fnAddu));
        // Store, clear, load back
        loadNext(iInstr(opAddiu, 0, 20, 16'h0100));
        loadNext(iInstr(opSw, 20, 2, 16'h0008));
        loadNext(iInstr(opAddiu, 0, 2, 16'h0000));
        loadNext(iInstr(opLw, 20, 2, 16'h0008));
        // Taken BEQ skips slot 24, untaken BNE runs slot 26
        loadNext(iInstr(opAddiu, 0, 21, 16'h0005));
        loadNext(iInstr(opAddiu, 0, 22, 16'h0005));
        loadNext(iInstr(opBeq, 21, 22, 16'h0001));
        loadNext(iInstr(opAddiu, 2, 2, 16'h0100));
        loadNext(iInstr(opBne, 21, 22, 16'h0001));
        loadNext(iInstr(opAddiu, 2, 2, 16'h0001));
        // Call and return, then halt
        loadNext(jInstr(opJal, addrOf(30)));
        loadNext(iInstr(opAddiu, 2, 2, 16'h0010));
        loadNext(jInstr(opJ, addrOf(32)));
        loadNext(iInstr(opAddiu, 2, 2, 16'h0200));
        loadNext(rInstr(31, 0, 0, 0, fnJr));
        loadNext(rInstr(0, 0, 0, 0, fnJr));

        // Expected register contents by the ISA rules
        x[8]  = {16'h8000, 16'h0000} | {16'h0000, 16'h00F0};
        x[9]  = {{16{1'b1}}, 16'hFFFD};
        x[10] = x[8] + x[9];
        x[11] = x[10] - x[9];
        x[12] = x[10] & x[9];
        x[13] = x[12] ^ x[9];
        x[14] = {31'd0, $signed(x[8]) < $signed(x[13])};
        x[15] = {31'd0, x[13] < x[8]};
        x[16] = x[13] << 4;
        x[17] = $signed(x[8]) >>> 8;
        x[18] = x[17] >> x[14][4:0];
        x[19] = {31'd0, $signed(x[9]) < $signed({{16{1'b1}}, 16'hFFFE})};
        expA  = (((x[16] + x[18]) ^ x[11]) + x[19]) + x[15];

        repeat (10) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        // First bus cycle is the reset vector fetch
        checkValue("read", {31'd0, read}, 32'd1);
        checkValue("write", {31'd0, write}, 32'd0);
        checkValue("active", {31'd0, active}, 32'd1);
        checkValue("address", address, resetVector);

        waitFetch(17);
        checkValue("register_v0", register_v0, expA);
        waitWrite(32'h0000_0100 + 32'h0000_0008, expA);
        waitFetch(20);
        checkValue("register_v0", register_v0, 32'd0);
        waitFetch(21);
        checkValue("register_v0", register_v0, expA);
        waitFetch(27);
        checkValue("register_v0", register_v0, expA + 32'h1);
        waitFetch(32);
        checkValue("register_v0", register_v0, expA + 32'h1 + 32'h200 + 32'h10);
        waitHalt();
        // Bus stays quiet once halted
        for (int n = 0; n < 40; n++) begin
            @(posedge clk);
            assert (!read && !write && !active) else
                failRun("Bus access seen after the CPU halted");
        end

        if (mipsCpuBus_inst.busAsserts_inst.failCount != 0) begin
            failRun("A bus protocol assertion failed");
        end else begin
            $display("=== PASS ===");
            $finish;
        end
    end

endmodule

/* dv/mipsCpuBusAsserts.sv */
// Avalon master protocol checks; attached to the CPU top level with bind from the testbench
`timescale 1ns/100ps

module mipsCpuBusAsserts (
    input logic          clk,
    input logic          reset,
    input logic          active,
    input logic          read,
    input logic          write,
    input logic          waitrequest,
    input mipsPkg::wordT address,
    input mipsPkg::wordT writedata,
    input logic [3:0]    byteenable
);
    import mipsPkg::*;

    // Number of failed checks so far
    int failCount = 0;

    // Stalled request keeps all its qualifiers
    stalledStable: assert property (@(posedge clk) disable iff (reset)
        (read || write) && waitrequest |=>
            (read == $past(read)) && (write == $past(write)) && (address == $past(address))
            && (byteenable == $past(byteenable)) && (!write || (writedata == $past(writedata))))
        else begin
            $error("Avalon request changed while waitrequest was high");
            failCount++;
        end

    // One direction at a time
    neverBoth: assert property (@(posedge clk) disable iff (reset) !(read && write))
        else begin
            $error("read and write high together");
            failCount++;
        end

    // Full word lanes on every transfer
    fullBytes: assert property (@(posedge clk) disable iff (reset)
        (read || write) |-> (byteenable == 4'b1111))
        else begin
            $error("byteenable not all ones during a transfer");
            failCount++;
        end

    // Halted CPU leaves the bus idle
    quietWhenHalted: assert property (@(posedge clk) disable iff (reset)
        !active |-> (!read && !write))
        else begin
            $error("Bus request while active is low");
            failCount++;
        end

endmodule

/* dv/avalonMemModel.sv */
// Word-addressed Avalon slave memory with random stalls; the testbench fills mem before reset ends
`timescale 1ns/100ps

module avalonMemModel (
    input  logic          clk,
    input  mipsPkg::wordT address,
    input  logic          read,
    input  logic          write,
    input  mipsPkg::wordT writedata,
    output logic          waitrequest,
    output mipsPkg::wordT readdata
);
    import mipsPkg::*;

    // 1024 words, indexed by address bits 11:2
    wordT mem [1024];

    // Stall generator state
    logic [31:0] rngState;

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] v;
        v = s;
        v = v ^ (v << 13);
        v = v ^ (v >> 17);
        v = v ^ (v << 5);
        return v;
    endfunction

    initial begin
        rngState    = 32'h6c01_55a9;
        waitrequest = 1'b1;
        readdata    = '0;
    end

    // New stall decision and read data on each falling edge
    always @(negedge clk) begin
        if (read || write) begin
            rngState = xorshift32(rngState);
            // Roughly three stalls in eight
            waitrequest = (rngState[2:0] < 3'd3);
        end else begin
            waitrequest = 1'b0;
        end
        readdata = mem[address[11:2]];
    end

    // Write lands in the completing cycle
    always @(posedge clk) begin
        if (write && !waitrequest) begin
            mem[address[11:2]] <= writedata;
        end
    end

endmodule

/* rtl/mipsCpuBus.sv */
// CPU top level; instantiate as the Avalon master and attach a word-addressed memory
`timescale 1ns/100ps

module mipsCpuBus (
    input  logic          clk,
    input  logic          reset,
    output logic          active,
    output mipsPkg::wordT register_v0,
    output mipsPkg::wordT address,
    output logic          write,
    output logic          read,
    input  logic          waitrequest,
    output mipsPkg::wordT writedata,
    output logic [3:0]    byteenable,
    input  mipsPkg::wordT readdata
);
    import mipsPkg::*;

    // Instruction register contents and its decode
    instrWordU instr;
    decodedT   ctrl;

    // Register file operands and write port
    wordT      rsVal;
    wordT      rtVal;
    regWriteT  rfWrite;

    // ALU operands and results
    wordT       aluB;
    logic [4:0] shamt;
    wordT       aluResult;
    logic       aluEq;

    busSequencer busSequencer_inst (
        .clk        (clk),
        .reset      (reset),
        .active     (active),
        .read       (read),
        .write      (write),
        .address    (address),
        .writedata  (writedata),
        .byteenable (byteenable),
        .waitrequest(waitrequest),
        .readdata   (readdata),
        .instr      (instr),
        .ctrl       (ctrl),
        .rsVal      (rsVal),
        .rtVal      (rtVal),
        .aluB       (aluB),
        .shamt      (shamt),
        .aluResult  (aluResult),
        .aluEq      (aluEq),
        .rfWrite    (rfWrite)
    );

    instrDecoder instrDecoder_inst (
        .instr(instr),
        .ctrl (ctrl)
    );

    // Source indices sit at the same place in R and I layouts
    regFile regFile_inst (
        .clk  (clk),
        .reset(reset),
        .rsIdx(instr.rFmt.rs),
        .rtIdx(instr.rFmt.rt),
        .rsVal(rsVal),
        .rtVal(rtVal),
        .wr   (rfWrite),
        .v0   (register_v0)
    );

    aluUnit aluUnit_inst (
        .op    (ctrl.aluOp),
        .a     (rsVal),
        .b     (aluB),
        .shamt (shamt),
        .result(aluResult),
        .eq    (aluEq)
    );

endmodule

/* rtl/busSequencer.sv */
// Fetch, execute, memory and halt control with PC, instruction register and Avalon master
`timescale 1ns/100ps

module busSequencer (
    input  logic              clk,
    input  logic              reset,
    output logic              active,
    output logic              read,
    output logic              write,
    output mipsPkg::wordT     address,
    output mipsPkg::wordT     writedata,
    output logic [3:0]        byteenable,
    input  logic              waitrequest,
    input  mipsPkg::wordT     readdata,
    output mipsPkg::instrWordU instr,
    input  mipsPkg::decodedT  ctrl,
    input  mipsPkg::wordT     rsVal,
    input  mipsPkg::wordT     rtVal,
    output mipsPkg::wordT     aluB,
    output logic [4:0]        shamt,
    input  mipsPkg::wordT     aluResult,
    input  logic              aluEq,
    output mipsPkg::regWriteT rfWrite
);
    import mipsPkg::*;

    typedef enum logic [1:0] {
        stFetch, stExec, stMem, stHalted
    } seqStateT;

    seqStateT  state;
    wordT      pc;
    instrWordU ir;

    // Derived values for the current instruction
    wordT immSext;
    wordT immExt;
    wordT pcPlus4;
    wordT branchTarget;
    wordT jumpTarget;
    wordT nextPc;
    logic branchTaken;

    assign instr = ir;

    // Immediate forms
    assign immSext = {{16{ir.iFmt.imm16[15]}}, ir.iFmt.imm16};
    assign immExt  = ctrl.immSigned ? immSext : {16'h0000, ir.iFmt.imm16};

    // Operand B and shift amount
    assign aluB  = ctrl.srcBImm ? immExt : rtVal;
    assign shamt = ctrl.shiftVar ? rsVal[4:0] : ir.rFmt.shamt;

    // Branch and jump targets, no delay slot
    assign pcPlus4      = pc + 32'd4;
    assign branchTarget = pcPlus4 + {immSext[29:0], 2'b00};
    assign jumpTarget   = {pcPlus4[31:28], ir.jFmt.target26, 2'b00};
    assign branchTaken  = (ctrl.branchEq && aluEq) || (ctrl.branchNe && !aluEq);

    always_comb begin
        if (ctrl.jumpReg) begin
            nextPc = rsVal;
        end else if (ctrl.jumpImm) begin
            nextPc = jumpTarget;
        end else if (branchTaken) begin
            nextPc = branchTarget;
        end else begin
            nextPc = pcPlus4;
        end
    end

    // Avalon master outputs
    // Data address comes out of the ALU as rs plus offset
    assign active     = (state != stHalted);
    assign read       = (state == stFetch) || ((state == stMem) && ctrl.memRead);
    assign write      = (state == stMem) && ctrl.memWrite;
    assign address    = (state == stMem) ? aluResult : pc;
    assign writedata  = rtVal;
    assign byteenable = 4'b1111;

    // Writeback in EXEC, or load data on MEM completion
    always_comb begin
        rfWrite.idx = ctrl.destReg;
        if (state == stMem) begin
            rfWrite.we   = ctrl.memRead && !waitrequest;
            rfWrite.data = readdata;
        end else begin
            rfWrite.we   = (state == stExec) && ctrl.rfWe && !ctrl.memRead;
            // Link address for JAL
            rfWrite.data = ctrl.link ? pcPlus4 : aluResult;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= stFetch;
            pc    <= resetVector;
        end else begin
            case (state)
                stFetch: begin
                    // Capture on the completing cycle
                    if (!waitrequest) begin
                        state <= stExec;
                    end
                end
                stExec: begin
                    pc <= nextPc;
                    if (ctrl.memRead || ctrl.memWrite) begin
                        state <= stMem;
                    end else if (nextPc == 32'd0) begin
                        state <= stHalted;
                    end else begin
                        state <= stFetch;
                    end
                end
                stMem: begin
                    if (!waitrequest) begin
                        state <= stFetch;
                    end
                end
                stHalted: begin
                    // Only reset leaves here
                    state <= stHalted;
                end
                default: begin
                    state <= stFetch;
                end
            endcase
        end
    end

    // Instruction register
    always_ff @(posedge clk) begin
        if ((state == stFetch) && !waitrequest) begin
            ir <= instrWordU'(readdata);
        end
    end

endmodule

/* rtl/instrDecoder.sv */
// Combinational instruction decoder; maps an instruction word to the control word
`timescale 1ns/100ps

module instrDecoder (
    input  mipsPkg::instrWordU instr,
    output mipsPkg::decodedT   ctrl
);
    import mipsPkg::*;

    always_comb begin
        // Everything off by default, so unknown codes act as a no-op
        ctrl = '0;
        ctrl.aluOp = aluAdd;
        // R-type writes rd, I-type writes rt
        ctrl.destReg = (instr.rFmt.op == opSpecial) ? instr.rFmt.rd : instr.iFmt.rt;

        case (instr.rFmt.op)
            opSpecial: begin
                ctrl.rfWe = 1'b1;
                case (instr.rFmt.funct)
                    fnAddu: ctrl.aluOp = aluAdd;
                    fnSubu: ctrl.aluOp = aluSub;
                    fnAnd:  ctrl.aluOp = aluAnd;
                    fnOr:   ctrl.aluOp = aluOr;
                    fnXor:  ctrl.aluOp = aluXor;
                    fnSlt:  ctrl.aluOp = aluSlt;
                    fnSltu: ctrl.aluOp = aluSltu;
                    fnSll:  ctrl.aluOp = aluSll;
                    fnSrl:  ctrl.aluOp = aluSrl;
                    fnSra:  ctrl.aluOp = aluSra;
                    // Variable shifts take the amount from rs
                    fnSllv: begin
                        ctrl.aluOp    = aluSll;
                        ctrl.shiftVar = 1'b1;
                    end
                    fnSrlv: begin
                        ctrl.aluOp    = aluSrl;
                        ctrl.shiftVar = 1'b1;
                    end
                    fnSrav: begin
                        ctrl.aluOp    = aluSra;
                        ctrl.shiftVar = 1'b1;
                    end
                    fnJr: begin
                        ctrl.rfWe    = 1'b0;
                        ctrl.jumpReg = 1'b1;
                    end
                    default: ctrl.rfWe = 1'b0;
                endcase
            end
            opJ: ctrl.jumpImm = 1'b1;
            opJal: begin
                ctrl.jumpImm = 1'b1;
                ctrl.link    = 1'b1;
                ctrl.rfWe    = 1'b1;
                ctrl.destReg = 5'd31;
            end
            // Branches compare rs against rt
            opBeq: ctrl.branchEq = 1'b1;
            opBne: ctrl.branchNe = 1'b1;
            opAddiu, opSlti, opSltiu: begin
                ctrl.rfWe      = 1'b1;
                ctrl.srcBImm   = 1'b1;
                ctrl.immSigned = 1'b1;
                // SLTIU sign-extends, then compares unsigned
                if (instr.rFmt.op == opSlti) begin
                    ctrl.aluOp = aluSlt;
                end else if (instr.rFmt.op == opSltiu) begin
                    ctrl.aluOp = aluSltu;
                end
            end
            // Logical immediates are zero-extended
            opAndi, opOri, opXori, opLui: begin
                ctrl.rfWe    = 1'b1;
                ctrl.srcBImm = 1'b1;
                case (instr.rFmt.op)
                    opAndi:  ctrl.aluOp = aluAnd;
                    opOri:   ctrl.aluOp = aluOr;
                    opXori:  ctrl.aluOp = aluXor;
                    default: ctrl.aluOp = aluLui;
                endcase
            end
            // Address is rs plus signed offset
            opLw, opSw: begin
                ctrl.srcBImm   = 1'b1;
                ctrl.immSigned = 1'b1;
                ctrl.memRead   = (instr.rFmt.op == opLw);
                ctrl.memWrite  = (instr.rFmt.op == opSw);
                ctrl.rfWe      = (instr.rFmt.op == opLw);
            end
            default: ctrl.rfWe = 1'b0;
        endcase
    end

endmodule

/* rtl/regFile.sv */
// General register file with two asynchronous read ports, one write port and a v0 tap
`timescale 1ns/100ps

module regFile (
    input  logic              clk,
    input  logic              reset,
    input  mipsPkg::regIdxT   rsIdx,
    input  mipsPkg::regIdxT   rtIdx,
    output mipsPkg::wordT     rsVal,
    output mipsPkg::wordT     rtVal,
    input  mipsPkg::regWriteT wr,
    output mipsPkg::wordT     v0
);
    import mipsPkg::*;

    wordT regs [32];

    // Asynchronous reads
    assign rsVal = regs[rsIdx];
    assign rtVal = regs[rtIdx];

    // Register 2 for debug
    assign v0 = regs[2];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wr.we && (wr.idx != 5'd0)) begin
            // Register 0 never written, stays zero
            regs[wr.idx] <= wr.data;
        end
    end

endmodule

/* rtl/aluUnit.sv */
// Combinational ALU for arithmetic, logic, compare and shift operations plus branch equality
`timescale 1ns/100ps

module aluUnit (
    input  mipsPkg::aluOpT op,
    input  mipsPkg::wordT  a,
    input  mipsPkg::wordT  b,
    input  logic [4:0]     shamt,
    output mipsPkg::wordT  result,
    output logic           eq
);
    import mipsPkg::*;

    // Compare results, zero-extended to a word
    wordT sltRes;
    wordT sltuRes;

    assign sltRes  = {31'd0, ($signed(a) < $signed(b))};
    assign sltuRes = {31'd0, (a < b)};

    // Branch condition, rs against rt
    assign eq = (a == b);

    always_comb begin
        case (op)
            // Wrapping add and subtract, no overflow trap
            aluAdd:  result = a + b;
            aluSub:  result = a - b;
            aluAnd:  result = a & b;
            aluOr:   result = a | b;
            aluXor:  result = a ^ b;
            aluSlt:  result = sltRes;
            aluSltu: result = sltuRes;
            // Shifts act on b, i.e. rt
            aluSll:  result = b << shamt;
            aluSrl:  result = b >> shamt;
            aluSra:  result = wordT'($signed(b) >>> shamt);
            // Immediate into the upper half
            aluLui:  result = {b[15:0], 16'h0000};
            default: result = a + b;
        endcase
    end

endmodule

/* rtl/mipsPkg.sv */
// Shared types and constants for the multicycle MIPS CPU; imported by every RTL module
package mipsPkg;

    // First fetch address after reset
    localparam logic [31:0] resetVector = 32'hBFC00000;

    typedef logic [31:0] wordT;
    typedef logic [4:0] regIdxT;

    // Primary opcodes of the supported subset
    typedef enum logic [5:0] {
        opSpecial = 6'd0,
        opJ       = 6'd2,
        opJal     = 6'd3,
        opBeq     = 6'd4,
        opBne     = 6'd5,
        opAddiu   = 6'd9,
        opSlti    = 6'd10,
        opSltiu   = 6'd11,
        opAndi    = 6'd12,
        opOri     = 6'd13,
        opXori    = 6'd14,
        opLui     = 6'd15,
        opLw      = 6'd35,
        opSw      = 6'd43
    } opcodeT;

    // Function codes for opSpecial
    typedef enum logic [5:0] {
        fnSll  = 6'd0,
        fnSrl  = 6'd2,
        fnSra  = 6'd3,
        fnSllv = 6'd4,
        fnSrlv = 6'd6,
        fnSrav = 6'd7,
        fnJr   = 6'd8,
        fnAddu = 6'd33,
        fnSubu = 6'd35,
        fnAnd  = 6'd36,
        fnOr   = 6'd37,
        fnXor  = 6'd38,
        fnSlt  = 6'd42,
        fnSltu = 6'd43
    } functT;

    // One instruction word, three field layouts
    typedef union packed {
        struct packed {
            opcodeT     op;
            regIdxT     rs;
            regIdxT     rt;
            regIdxT     rd;
            logic [4:0] shamt;
            functT      funct;
        } rFmt;
        struct packed {
            opcodeT      op;
            regIdxT      rs;
            regIdxT      rt;
            logic [15:0] imm16;
        } iFmt;
        struct packed {
            opcodeT      op;
            logic [25:0] target26;
        } jFmt;
    } instrWordU;

    typedef enum logic [3:0] {
        aluAdd, aluSub, aluAnd, aluOr, aluXor, aluSlt, aluSltu, aluSll, aluSrl, aluSra, aluLui
    } aluOpT;

    // Control word produced by the decoder
    typedef struct packed {
        aluOpT  aluOp;
        logic   srcBImm;
        logic   immSigned;
        logic   shiftVar;
        logic   rfWe;
        regIdxT destReg;
        logic   memRead;
        logic   memWrite;
        logic   branchEq;
        logic   branchNe;
        logic   jumpImm;
        logic   jumpReg;
        logic   link;
    } decodedT;

    // Register file write port
    typedef struct packed {
        logic   we;
        regIdxT idx;
        wordT   data;
    } regWriteT;

endpackage
